// ==== design/fetch_defines.svh ====
//////////////////////////////////////////////////////////////////////
// Width macros for the instruction prefetch path
// Opcode marker that tells a 32-bit instruction from a compressed one
//////////////////////////////////////////////////////////////////////

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Byte address width seen by the core and the memory
`define FETCH_ADDR_W 32

// One memory word holds two halfwords
`define FETCH_WORD_W 32

// Compressed instructions are one halfword wide
`define FETCH_HALF_W 16

// Low two opcode bits of every 32-bit instruction
// Any other value marks a compressed instruction
`define FETCH_FULL_OPC 2'b11

`endif

// ==== design/fetch_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Types shared by the prefetch buffer blocks
// Fetch word union, bus request and response structs, bus FSM states
//////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

package fetch_pkg;

  // One memory word, read whole for an aligned 32-bit instruction
  // or as two halfwords when alignment or compression splits it
  typedef union packed {
    logic [`FETCH_WORD_W-1:0] word;  // Whole instruction word
    struct packed {
      logic [`FETCH_HALF_W-1:0] hi;  // Halfword at byte offset 2
      logic [`FETCH_HALF_W-1:0] lo;  // Halfword at byte offset 0
    } half;
  } fetch_word_u;

  // Request from the assembler toward the bus controller
  typedef struct packed {
    logic                      req;    // A word is wanted
    logic [`FETCH_ADDR_W-3:0]  waddr;  // Word address, byte bits dropped
    logic                      flush;  // Branch seen, any owed response is stale
  } fetch_req_t;

  // Response forwarded from the bus controller
  typedef struct packed {
    logic        valid;  // Data is for the current request
    fetch_word_u data;   // Word as returned by the memory
  } fetch_rsp_t;

  // Memory bus FSM
  typedef enum logic [1:0] {
    IDLE,          // Nothing outstanding
    WAIT_GNT,      // Request driven, grant still missing
    WAIT_RVALID,   // Granted, data owed
    WAIT_ABORTED   // Granted before a branch, data will be dropped
  } bus_state_e;

endpackage

// ==== design/fetch_bus_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Memory bus controller for the prefetch buffer
// Four state FSM with grant wait, response wait and stale abort
//////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module fetch_bus_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,

  // Assembler side
  input  fetch_pkg::fetch_req_t      fetch_req_i,
  output fetch_pkg::fetch_rsp_t      fetch_rsp_o,

  // Instruction memory side
  output logic                       instr_req_o,
  output logic [`FETCH_ADDR_W-1:0]   instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic [`FETCH_WORD_W-1:0]   instr_rdata_i,
  input  logic                       instr_rvalid_i,

  // Status
  output logic                       bus_busy_o
);

  fetch_pkg::bus_state_e     state_q, state_d;  // Bus FSM
  logic [`FETCH_ADDR_W-3:0]  addr_q, addr_d;    // Word address of the access on the bus
  logic                      stale_q, stale_d;  // Branch came while the grant was pending
  logic                      rsp_valid;         // Forward the returned word this cycle

  ////////////////////////////////////////////////////////////////////
  // Next state and bus outputs
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    addr_d    = addr_q;
    stale_d   = stale_q;
    rsp_valid = 1'b0;

    // By default the bus shows the address the assembler asks for
    instr_req_o  = 1'b0;
    instr_addr_o = {fetch_req_i.waddr, 2'b00};

    unique case (state_q)
      fetch_pkg::IDLE: begin
        if (fetch_req_i.req) begin  // New access that may share the cycle with a flush
          instr_req_o = 1'b1;
          addr_d      = fetch_req_i.waddr;
          stale_d     = 1'b0;
          if (instr_gnt_i) begin
            state_d = fetch_pkg::WAIT_RVALID;  // Granted in the request cycle
          end else begin
            state_d = fetch_pkg::WAIT_GNT;
          end
        end
      end

      fetch_pkg::WAIT_GNT: begin
        // The request cannot be withdrawn, so keep the registered address
        instr_req_o  = 1'b1;
        instr_addr_o = {addr_q, 2'b00};
        if (instr_gnt_i) begin
          stale_d = 1'b0;
          if (stale_q || fetch_req_i.flush) begin
            state_d = fetch_pkg::WAIT_ABORTED;  // Its data is no longer wanted
          end else begin
            state_d = fetch_pkg::WAIT_RVALID;
          end
        end else if (fetch_req_i.flush) begin
          stale_d = 1'b1;  // Remember the branch until the grant comes
        end
      end

      fetch_pkg::WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // A branch in the same cycle turns the word stale
          rsp_valid = !fetch_req_i.flush;
          state_d   = fetch_pkg::IDLE;
        end else if (fetch_req_i.flush) begin
          state_d = fetch_pkg::WAIT_ABORTED;  // Wait out the owed word
        end
      end

      fetch_pkg::WAIT_ABORTED: begin
        // Swallow the stale word, then start the access the assembler holds
        if (instr_rvalid_i) begin
          if (fetch_req_i.req) begin
            instr_req_o = 1'b1;
            addr_d      = fetch_req_i.waddr;
            if (instr_gnt_i) begin
              state_d = fetch_pkg::WAIT_RVALID;
            end else begin
              state_d = fetch_pkg::WAIT_GNT;
            end
          end else begin
            state_d = fetch_pkg::IDLE;
          end
        end
      end

      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Response toward the assembler
  ////////////////////////////////////////////////////////////////////

  // Data goes straight through and only the valid flag is qualified
  always_comb begin
    fetch_rsp_o.valid     = rsp_valid;
    fetch_rsp_o.data.word = instr_rdata_i;
  end

  // Busy covers the request cycle too, before the FSM leaves IDLE
  assign bus_busy_o = (state_q != fetch_pkg::IDLE) || instr_req_o;

  ////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::IDLE;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      stale_q <= stale_d;
    end
  end

  // Address of the access that waits for its grant
  always_ff @(posedge clk) begin
    addr_q <= addr_d;
  end

endmodule

// ==== design/instr_assembler.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction assembler of the prefetch buffer
// Program counter, halfword buffer and response holding register
// Layout decode and output to the decode stage
//////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module instr_assembler (
  input  logic                       clk,
  input  logic                       rst_n,

  // Decode side
  input  logic                       req_i,
  input  logic                       branch_i,
  input  logic [`FETCH_ADDR_W-1:0]   addr_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output logic [`FETCH_WORD_W-1:0]   rdata_o,
  output logic [`FETCH_ADDR_W-1:0]   addr_o,

  // Bus controller side
  output fetch_pkg::fetch_req_t      fetch_req_o,
  input  fetch_pkg::fetch_rsp_t      fetch_rsp_i
);

  // Five ways an instruction can sit in the buffers
  typedef enum logic [2:0] {
    LAY_FULL,      // Whole word from the holding register
    LAY_C_LOW,     // Compressed in the low half of the held word
    LAY_C_HIGH,    // Compressed in the high half, reached by a branch
    LAY_C_HELD,    // Compressed already in the halfword buffer
    LAY_STRADDLE   // Low part in the halfword buffer, high part in the next word
  } layout_e;

  logic [`FETCH_ADDR_W-1:0] pc_q, pc_d;                      // Address of the next instruction
  logic                     half_valid_q, half_valid_d;      // Halfword at pc is buffered
  logic                     hold_valid_q, hold_valid_d;      // Next needed word is held
  logic [`FETCH_HALF_W-1:0] half_q;                          // Halfword at pc when pc[1] is set
  fetch_pkg::fetch_word_u   hold_q;                          // Returned word waiting for use

  layout_e                  layout;
  fetch_pkg::fetch_word_u   strad_word;   // Source of the upper part of a straddler
  logic                     instr_is_c;   // Offered instruction is compressed
  logic [`FETCH_ADDR_W-1:0] pc_step;
  logic                     consume;
  logic                     need_word;
  logic                     half_load, hold_load;
  logic [`FETCH_HALF_W-1:0] half_src;

  ////////////////////////////////////////////////////////////////////
  // Layout decode and output assembly
  ////////////////////////////////////////////////////////////////////

  // The upper part can come live from the bus when nothing is held yet
  assign strad_word = hold_valid_q ? hold_q : fetch_rsp_i.data;

  always_comb begin
    if (half_valid_q) begin
      layout = (half_q[1:0] != `FETCH_FULL_OPC) ? LAY_C_HELD : LAY_STRADDLE;
    end else if (pc_q[1]) begin
      layout = LAY_C_HIGH;  // A full one here goes to the halfword buffer at capture
    end else if (hold_q.half.lo[1:0] != `FETCH_FULL_OPC) begin
      layout = LAY_C_LOW;
    end else begin
      layout = LAY_FULL;
    end
  end

  always_comb begin
    unique case (layout)
      LAY_FULL:     rdata_o = hold_q.word;
      LAY_C_LOW:    rdata_o = {{`FETCH_HALF_W{1'b0}}, hold_q.half.lo};
      LAY_C_HIGH:   rdata_o = {{`FETCH_HALF_W{1'b0}}, hold_q.half.hi};
      LAY_C_HELD:   rdata_o = {{`FETCH_HALF_W{1'b0}}, half_q};
      LAY_STRADDLE: rdata_o = {strad_word.half.lo, half_q};
      default:      rdata_o = hold_q.word;
    endcase
  end

  always_comb begin
    unique case (layout)
      LAY_C_HELD:   valid_o = 1'b1;                               // No bus access at all
      LAY_STRADDLE: valid_o = hold_valid_q || fetch_rsp_i.valid;  // Same cycle as the data
      default:      valid_o = hold_valid_q;
    endcase
  end

  assign addr_o     = pc_q;  // Always the first halfword of the instruction
  assign instr_is_c = (layout != LAY_FULL) && (layout != LAY_STRADDLE);
  assign pc_step    = instr_is_c ? `FETCH_ADDR_W'(2) : `FETCH_ADDR_W'(4);
  assign consume    = valid_o && ready_i && !branch_i;  // A branch wins over the handshake

  ////////////////////////////////////////////////////////////////////
  // Request toward the bus controller
  ////////////////////////////////////////////////////////////////////

  // No fetch while a word is held or the held halfword is a whole instruction
  assign need_word = !hold_valid_q && !(half_valid_q && layout == LAY_C_HELD);

  always_comb begin
    fetch_req_o.req   = req_i && need_word && !branch_i;
    fetch_req_o.waddr = pc_q[`FETCH_ADDR_W-1:2] + (`FETCH_ADDR_W-2)'(half_valid_q);
    fetch_req_o.flush = branch_i;
  end

  ////////////////////////////////////////////////////////////////////
  // Buffer and counter update
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    pc_d         = pc_q;
    half_valid_d = half_valid_q;
    hold_valid_d = hold_valid_q;
    half_load    = 1'b0;
    hold_load    = 1'b0;
    half_src     = hold_q.half.hi;

    if (branch_i) begin
      pc_d         = addr_i;
      half_valid_d = 1'b0;
      hold_valid_d = 1'b0;
    end else begin
      if (fetch_rsp_i.valid) begin
        if (!half_valid_q && pc_q[1] &&
            fetch_rsp_i.data.half.hi[1:0] == `FETCH_FULL_OPC) begin
          // Branch target straddles so its low part is kept and the fetch goes on
          half_load    = 1'b1;
          half_src     = fetch_rsp_i.data.half.hi;
          half_valid_d = 1'b1;
        end else begin
          hold_load    = 1'b1;
          hold_valid_d = 1'b1;
        end
      end

      if (consume) begin
        pc_d = pc_q + pc_step;
        unique case (layout)
          LAY_C_LOW: begin  // Keep the upper half for the next instruction
            half_load    = 1'b1;
            half_valid_d = 1'b1;
            hold_valid_d = 1'b0;
          end
          LAY_C_HELD: half_valid_d = 1'b0;
          LAY_STRADDLE: begin  // Upper half of the second word is the next start
            half_load    = 1'b1;
            half_src     = strad_word.half.hi;
            hold_valid_d = 1'b0;
          end
          default: hold_valid_d = 1'b0;  // Full or high compressed uses the whole word
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q         <= '0;
      half_valid_q <= 1'b0;
      hold_valid_q <= 1'b0;
    end else begin
      pc_q         <= pc_d;
      half_valid_q <= half_valid_d;
      hold_valid_q <= hold_valid_d;
    end
  end

  // Held word and halfword payloads
  always_ff @(posedge clk) begin
    if (hold_load) hold_q <= fetch_rsp_i.data;
    if (half_load) half_q <= half_src;
  end

endmodule

// ==== design/prefetch_buffer_top.sv ====
//////////////////////////////////////////////////////////////////////
// Prefetch buffer top level
// Bus controller and instruction assembler with the busy status
//////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module prefetch_buffer_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // Decode stage
  input  logic                       req_i,
  input  logic                       branch_i,
  input  logic [`FETCH_ADDR_W-1:0]   addr_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output logic [`FETCH_WORD_W-1:0]   rdata_o,
  output logic [`FETCH_ADDR_W-1:0]   addr_o,

  // Instruction memory
  output logic                       instr_req_o,
  output logic [`FETCH_ADDR_W-1:0]   instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic [`FETCH_WORD_W-1:0]   instr_rdata_i,
  input  logic                       instr_rvalid_i,

  // Status
  output logic                       busy_o
);

  fetch_pkg::fetch_req_t fetch_req;  // Word wanted by the assembler
  fetch_pkg::fetch_rsp_t fetch_rsp;  // Word returned for it

  // Turns words into instructions for decode
  instr_assembler i_instr_assembler (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .branch_i    (branch_i),
    .addr_i      (addr_i),
    .ready_i     (ready_i),
    .valid_o     (valid_o),
    .rdata_o     (rdata_o),
    .addr_o      (addr_o),
    .fetch_req_o (fetch_req),
    .fetch_rsp_i (fetch_rsp)
  );

  // Only master on the instruction bus
  fetch_bus_ctrl i_fetch_bus_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_req_i    (fetch_req),
    .fetch_rsp_o    (fetch_rsp),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .bus_busy_o     (busy_o)  // Busy is the bus activity alone
  );

endmodule

// ==== verif/imem_model.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction memory model for the prefetch buffer testbench
// Random grant delay, response one cycle after each grant
//////////////////////////////////////////////////////////////////////

module imem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic [1:0]  delay_i,   // Grant delay used for the access after the next grant
  output logic        gnt_o,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  logic [31:0] file_img [0:19];  // Sixteen program words, then the branch targets
  logic [1:0]  wait_q;           // Cycles the pending request has waited
  logic [1:0]  delay_q;          // Wait needed before the next grant

  initial begin
    $readmemh("verif/fetch_patterns.hex", file_img);
  end

  // Grant is offered once the wait is over and only counts with a request
  assign gnt_o = (wait_q >= delay_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q   <= 2'd0;
      delay_q  <= 2'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= req_i && gnt_o;  // Answer in the cycle after the grant
      if (req_i && gnt_o) begin
        wait_q  <= 2'd0;
        delay_q <= delay_i;
        // Four word address bits select the word, so the image repeats every 64 bytes
        rdata_o <= file_img[{1'b0, addr_i[5:2]}];
      end else if (req_i) begin
        wait_q <= wait_q + 2'd1;
      end
    end
  end

endmodule

// ==== verif/tb_prefetch_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the prefetch buffer
// Memory model, random back-pressure, branches and a reference walk
//////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module tb_prefetch_buffer;

  localparam int BEAT_LIMIT = 400;  // Cycles allowed for one group of beats
  localparam int WAIT_LIMIT = 200;  // Cycles allowed for a branch or for the bus to drain

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     req;
  logic                     branch;
  logic [`FETCH_ADDR_W-1:0] branch_addr;
  logic                     ready;
  logic                     valid;
  logic [`FETCH_WORD_W-1:0] rdata;
  logic [`FETCH_ADDR_W-1:0] addr;
  logic                     instr_req;
  logic [`FETCH_ADDR_W-1:0] instr_addr;
  logic                     instr_gnt;
  logic [`FETCH_WORD_W-1:0] instr_rdata;
  logic                     instr_rvalid;
  logic                     busy;
  logic [1:0]               gnt_delay;  // Grant delay handed to the memory model

  logic [`FETCH_WORD_W-1:0] patterns [0:19];  // Memory image followed by the branch targets
  logic [31:0]              rnd_state;
  logic [`FETCH_ADDR_W-1:0] ref_pc;           // Next address decode should see
  int                       beats;            // Instructions consumed so far
  int                       err_count;
  logic                     timed_out;
  logic                     stall_all;        // Keep ready low so the bus drains
  logic                     was_stalled;      // Offer was held back in the last cycle
  logic [`FETCH_WORD_W-1:0] held_rdata;
  logic [`FETCH_ADDR_W-1:0] held_addr;
  logic                     saw_bus_req;      // Bus access seen in the last sampled cycle
  logic                     saw_busy;

  always #5 clk = ~clk;

  prefetch_buffer_top i_prefetch_buffer_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .branch_i       (branch),
    .addr_i         (branch_addr),
    .ready_i        (ready),
    .valid_o        (valid),
    .rdata_o        (rdata),
    .addr_o         (addr),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rdata_i  (instr_rdata),
    .instr_rvalid_i (instr_rvalid),
    .busy_o         (busy)
  );

  imem_model i_imem_model (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .delay_i  (gnt_delay),
    .gnt_o    (instr_gnt),
    .rdata_o  (instr_rdata),
    .rvalid_o (instr_rvalid)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference walk and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Halfword of the image at a byte address
  // The image repeats every 64 bytes
  function automatic logic [15:0] half_at(input logic [`FETCH_ADDR_W-1:0] a);
    fetch_pkg::fetch_word_u w;
    w.word = patterns[{1'b0, a[5:2]}];
    return a[1] ? w.half.hi : w.half.lo;
  endfunction

  // Compressed when the low two bits are not 11 and then the upper half reads zero
  function automatic logic [31:0] expected_instr(input logic [`FETCH_ADDR_W-1:0] a);
    logic [15:0] lo;
    logic [31:0] instr;
    lo = half_at(a);
    if (lo[1:0] != 2'b11) instr = {16'h0000, lo};
    else instr = {half_at(a + 32'd2), lo};
    return instr;
  endfunction

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    err_count++;
    $display("** Error %s: expected %h, actual %h at %0t", test, expected, actual, $time);
  endtask

  task automatic report_timeout(input string what);
    err_count++;
    timed_out = 1'b1;
    $display("Timeout while waiting for %s at %0t", what, $time);
  endtask

  task automatic check_quiet(input string test);
    if (valid !== 1'b0) report_mismatch({test, "_valid"}, 32'd0, {31'd0, valid});
    if (instr_req !== 1'b0) report_mismatch({test, "_instr_req"}, 32'd0, {31'd0, instr_req});
    if (busy !== 1'b0) report_mismatch({test, "_busy"}, 32'd0, {31'd0, busy});
  endtask

  //////////////////////////////////////////////////////////////////////
  // One clock cycle sampled at the falling edge and driven at the rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic sample_cycle();
    logic [31:0] exp_data;
    @(negedge clk);
    if (instr_req) begin  // Bus side rules
      if (instr_addr[1:0] !== 2'b00)
        report_mismatch("bus_align", 32'd0, {30'd0, instr_addr[1:0]});
      if (busy !== 1'b1) report_mismatch("busy", 32'd1, {31'd0, busy});
    end
    saw_bus_req = instr_req;
    saw_busy    = busy;
    // A stalled offer stays put unless a branch takes over
    if (was_stalled && !branch) begin
      if (valid !== 1'b1) report_mismatch("stall_valid", 32'd1, {31'd0, valid});
      if (addr !== held_addr) report_mismatch("stall_addr", held_addr, addr);
      if (rdata !== held_rdata) report_mismatch("stall_rdata", held_rdata, rdata);
    end
    was_stalled = valid && !ready && !branch;
    held_addr   = addr;
    held_rdata  = rdata;
    if (valid && ready && !branch) begin  // Consumed beat against the reference walk
      exp_data = expected_instr(ref_pc);
      if (addr !== ref_pc) report_mismatch("stream_addr", ref_pc, addr);
      if (rdata !== exp_data) report_mismatch("stream_rdata", exp_data, rdata);
      ref_pc = ref_pc + ((exp_data[1:0] != 2'b11) ? 32'd2 : 32'd4);
      beats++;
    end
  endtask

  task automatic drive_cycle(input logic do_branch, input logic [`FETCH_ADDR_W-1:0] target);
    @(posedge clk);
    rnd_state = next_random(rnd_state);
    ready     <= !stall_all && (rnd_state[2:0] > 3'd1);  // Low about a quarter of the time
    gnt_delay <= rnd_state[9:8];
    branch    <= do_branch;
    if (do_branch) begin
      branch_addr <= target;
      ref_pc = target;  // Nothing is consumed in the branch cycle
    end
  endtask

  // A branch that needs the bus waits for an access, so a response is owed
  task automatic run_cycle(input logic br_want, input logic br_need_bus,
                           input logic [`FETCH_ADDR_W-1:0] target, output logic br_taken);
    sample_cycle();
    br_taken = br_want && (saw_bus_req || !br_need_bus);
    drive_cycle(br_taken, target);
  endtask

  task automatic consume_beats(input int n, input string what);
    int   goal;
    int   cycles;
    logic unused_taken;
    goal   = beats + n;
    cycles = 0;
    while (!timed_out && beats < goal && cycles < BEAT_LIMIT) begin
      run_cycle(1'b0, 1'b0, '0, unused_taken);
      cycles++;
    end
    if (!timed_out && beats < goal) report_timeout(what);
  endtask

  task automatic take_branch(input logic [`FETCH_ADDR_W-1:0] target, input logic need_bus);
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    while (!timed_out && !taken && cycles < WAIT_LIMIT) begin
      run_cycle(1'b1, need_bus, target, taken);
      cycles++;
    end
    if (!timed_out && !taken) report_timeout("a bus access to branch over");
  endtask

  task automatic drain_bus();
    int   cycles;
    logic idle;
    logic unused_taken;
    cycles    = 0;
    idle      = 1'b0;
    stall_all = 1'b1;
    while (!timed_out && !idle && cycles < WAIT_LIMIT) begin
      run_cycle(1'b0, 1'b0, '0, unused_taken);
      idle = !saw_busy;
      cycles++;
    end
    if (!timed_out && !idle) report_timeout("the bus to go idle");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    ready       = 1'b0;
    gnt_delay   = 2'd0;
    rnd_state   = 32'hac390003;
    ref_pc      = '0;
    beats       = 0;
    err_count   = 0;
    timed_out   = 1'b0;
    stall_all   = 1'b0;
    was_stalled = 1'b0;
    held_rdata  = '0;
    held_addr   = '0;
    saw_bus_req = 1'b0;
    saw_busy    = 1'b0;
    $readmemh("verif/fetch_patterns.hex", patterns);

    for (int i = 0; i < 8; i++) begin  // Quiet through the whole reset
      @(negedge clk);
      check_quiet("reset");
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_quiet("after_reset");  // Still quiet while decode asks for nothing
    @(posedge clk);
    req   <= 1'b1;
    ready <= 1'b1;

    consume_beats(30, "the sequential stream");
    // First branch goes at once and the others go over an owed response
    for (int t = 0; t < 4; t++) begin
      take_branch(patterns[5'd16 + 5'(t)], t != 0);
      consume_beats(10, "beats after a branch");
    end
    drain_bus();

    $display("Beats checked: %0d, error count: %0d", beats, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/fetch_pkg.sv
design/fetch_bus_ctrl.sv
design/instr_assembler.sv
design/prefetch_buffer_top.sv
verif/imem_model.sv
verif/tb_prefetch_buffer.sv

// ==== Makefile ====
# Verilator flow for the prefetch buffer

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_prefetch_buffer
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILE_LIST)

# The simulator status is ignored, the log decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/fetch_patterns.hex ====
// Lines 0 to 15 hold the instruction memory image, one 32-bit word each
// Lines 16 to 19 hold the branch target byte addresses
00500093
80824505
82930485
458100a2
00b30333
97020705
01c000ef
05334601
859340b5
852200c5
46810611
fe069ee3
85b38d2a
029100d5
00f00713
8082853e
00000016
0000001e
0000002c
00000032
